// ==== hdl/ifu_defines.svh ====
//**********************************************************************
// reset pc, fetch buffer depth and fetch path widths
//**********************************************************************
`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// first fetch pc out of reset
`define IFU_RESET_PC   32'h0000_0100

// fetch buffer entries, also the credit count after reset or flush
`define IFU_FB_DEPTH   4

`define IFU_BLK_W      64     // one fetch block per memory beat
`define IFU_PARCELS    4      // halfword parcels in a block
`define IFU_PC_W       32     // byte address width

`endif

// ==== hdl/ifu_pkg.sv ====
//**********************************************************************
// fetch path types: fetch block, decode packet, fetch and length enums
//**********************************************************************
`include "ifu_defines.svh"

package ifu_pkg;

   localparam int PIDX_W = $clog2(`IFU_PARCELS);     // parcel index width

   // one returned memory block as held in the fetch buffer
   typedef struct packed {
      logic [`IFU_PC_W-1:0]   pc;      // block aligned address
      logic [`IFU_BLK_W-1:0]  data;    // parcel 0 in the low halfword
      logic                   err;     // bus error on this block
      logic [PIDX_W-1:0]      start;   // first valid parcel, nonzero after redirect
   } fetch_blk_t;

   // one instruction handed to decode
   typedef struct packed {
      logic [`IFU_PC_W-1:0]   pc;
      logic [31:0]            instr;   // upper half zero when compressed
      logic                   pc4;     // 32-bit instruction
      logic                   fault;   // access fault on any part
   } instr_pkt_t;

   typedef logic [`IFU_PARCELS-1:0][15:0] parcels_t;   // block seen as halfwords

   typedef enum logic {
      FETCH_RUN,                       // issuing sequential requests
      FETCH_HALT                       // parked until a redirecting flush
   } fetch_state_e;

   typedef enum logic {
      LEN_16,
      LEN_32
   } instr_len_e;

   // rvc rule, low bits 11 mean a full 32-bit encoding
   function automatic instr_len_e decode_len(input logic [15:0] parcel);
      return (parcel[1:0] == 2'b11) ? LEN_32 : LEN_16;
   endfunction

endpackage

// ==== hdl/ifu_fetch_ctl.sv ====
//**********************************************************************
// fetch controller: block requests under credit control, flush
// redirect and halt, response filter building fetch blocks
//**********************************************************************
`timescale 1ns/1ps
`include "ifu_defines.svh"

module ifu_fetch_ctl (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     flush_i,            // flush from the pipe
   input  logic [`IFU_PC_W-1:0]     flush_pc_i,         // restart pc, halfword aligned
   input  logic                     flush_noredir_i,    // stop fetching, no restart
   input  logic                     credit_i,           // one buffer entry freed
   input  logic                     mem_rsp_valid_i,
   input  logic [`IFU_BLK_W-1:0]    mem_rsp_data_i,
   input  logic                     mem_rsp_err_i,
   output logic                     mem_req_o,
   output logic [`IFU_PC_W-1:0]     mem_addr_o,         // block aligned
   output logic                     blk_push_o,
   output ifu_pkg::fetch_blk_t      blk_o
);
   import ifu_pkg::*;

   localparam int CRD_W = $clog2(`IFU_FB_DEPTH + 1);
   localparam int OFS_W = $clog2(`IFU_BLK_W / 8);      // byte offset bits in a block
   localparam int BLK_BYTES = `IFU_BLK_W / 8;
   localparam logic [`IFU_PC_W-1:0] RESET_PC = `IFU_RESET_PC;
   localparam logic [CRD_W-1:0] FULL_CRD = CRD_W'(`IFU_FB_DEPTH);

   fetch_state_e           state_q;
   logic [`IFU_PC_W-1:0]   pc_q;           // next sequential block address
   logic [PIDX_W-1:0]      start_q;        // start parcel of that block
   logic [CRD_W-1:0]       credits_q;      // free buffer entries not yet claimed
   logic                   req_q;          // request on the bus this cycle
   logic [`IFU_PC_W-1:0]   req_addr_q;
   logic [PIDX_W-1:0]      req_start_q;
   logic                   rsp_pend_q;     // response for last cycle's request due now
   logic [`IFU_PC_W-1:0]   rsp_pc_q;       // pc of the in-flight request
   logic [PIDX_W-1:0]      rsp_start_q;
   logic                   issue;
   logic [`IFU_PC_W-1:0]   flush_blk;

   assign issue     = (state_q == FETCH_RUN) && (credits_q != '0) && !flush_i;
   assign flush_blk = {flush_pc_i[`IFU_PC_W-1:OFS_W], {OFS_W{1'b0}}};

   //**********************************************************************
   // fetch state, next pc and credits
   //**********************************************************************
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= FETCH_RUN;
         pc_q       <= {RESET_PC[`IFU_PC_W-1:OFS_W], {OFS_W{1'b0}}};
         start_q    <= RESET_PC[OFS_W-1:1];
         credits_q  <= FULL_CRD;
         req_q      <= 1'b0;
         rsp_pend_q <= 1'b0;
      end else if (flush_i) begin
         // buffer empties this cycle, the redirect request takes one credit
         credits_q  <= FULL_CRD - CRD_W'(!flush_noredir_i);
         start_q    <= '0;
         rsp_pend_q <= 1'b0;                          // drop the response landing next
         if (flush_noredir_i) begin
            state_q <= FETCH_HALT;
            req_q   <= 1'b0;
         end else begin
            state_q <= FETCH_RUN;
            req_q   <= 1'b1;                          // flush block goes out next cycle
            pc_q    <= flush_blk + BLK_BYTES;
         end
      end else begin
         req_q      <= issue;
         rsp_pend_q <= req_q;
         credits_q  <= credits_q - CRD_W'(issue) + CRD_W'(credit_i);
         if (issue) begin
            pc_q    <= pc_q + BLK_BYTES;
            start_q <= '0;                            // later blocks start at parcel 0
         end
      end
   end

   // request and in-flight payload
   always_ff @(posedge clk) begin
      if (flush_i && !flush_noredir_i) begin
         req_addr_q  <= flush_blk;
         req_start_q <= flush_pc_i[OFS_W-1:1];        // parcel holding the target
      end else if (issue) begin
         req_addr_q  <= pc_q;
         req_start_q <= start_q;
      end
      rsp_pc_q    <= req_addr_q;                      // fixed one cycle latency
      rsp_start_q <= req_start_q;
   end

   assign mem_req_o  = req_q;
   assign mem_addr_o = req_addr_q;

   //**********************************************************************
   // response to fetch block
   //**********************************************************************
   assign blk_push_o = mem_rsp_valid_i && rsp_pend_q && !flush_i;

   always_comb begin
      blk_o.pc    = rsp_pc_q;
      blk_o.data  = mem_rsp_data_i;
      blk_o.err   = mem_rsp_err_i;                    // marks every parcel of the block
      blk_o.start = rsp_start_q;
   end

endmodule

// ==== hdl/ifu_fetch_buf.sv ====
//**********************************************************************
// fetch buffer: circular FIFO of fetch blocks with credit return
//**********************************************************************
`timescale 1ns/1ps
`include "ifu_defines.svh"

module ifu_fetch_buf (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  flush_i,         // empties the buffer
   input  logic                  blk_push_i,
   input  ifu_pkg::fetch_blk_t   blk_i,
   input  logic                  pop_i,           // aligner done with head
   output ifu_pkg::fetch_blk_t   head_o,
   output logic                  head_valid_o,
   output logic                  credit_o         // one pulse per released entry
);
   import ifu_pkg::*;

   localparam int PTR_W = $clog2(`IFU_FB_DEPTH);

   fetch_blk_t       mem_q [`IFU_FB_DEPTH];      // block storage
   logic [PTR_W:0]   wr_ptr_q;                   // extra msb tells full from empty
   logic [PTR_W:0]   rd_ptr_q;
   logic             push;
   logic             pop;

   // credits bound the occupancy, so a push never meets a full buffer
   assign push = blk_push_i && !flush_i;
   assign pop  = pop_i && head_valid_o && !flush_i;

   //**********************************************************************
   // pointers
   //**********************************************************************
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else if (flush_i) begin
         wr_ptr_q <= '0;                         // drop everything held
         rd_ptr_q <= '0;
      end else begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // storage write, visible at the head one cycle later
   always_ff @(posedge clk) begin
      if (push)
         mem_q[wr_ptr_q[PTR_W-1:0]] <= blk_i;
   end

   //**********************************************************************
   // head and credit
   //**********************************************************************
   assign head_valid_o = (wr_ptr_q != rd_ptr_q);
   assign head_o       = mem_q[rd_ptr_q[PTR_W-1:0]];
   assign credit_o     = pop;                    // none while flushing

endmodule

// ==== hdl/ifu_aligner.sv ====
//**********************************************************************
// aligner: parcel extraction, 16/32-bit length decode, straddle carry
// and decode valid/ready handshake
//**********************************************************************
`timescale 1ns/1ps
`include "ifu_defines.svh"

module ifu_aligner (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  flush_i,          // drop partial state
   input  ifu_pkg::fetch_blk_t   head_i,           // oldest buffered block
   input  logic                  head_valid_i,
   input  logic                  dec_ready_i,      // decode can take one
   output logic                  pop_o,            // head block fully used
   output ifu_pkg::instr_pkt_t   instr_o,
   output logic                  instr_valid_o
);
   import ifu_pkg::*;

   localparam logic [PIDX_W-1:0] LAST = PIDX_W'(`IFU_PARCELS - 1);

   logic [PIDX_W-1:0]      idx_q;             // next parcel in the head block
   logic                   mid_q;             // head partly consumed, idx_q in use
   logic                   carry_vld_q;       // first half of a straddler held
   logic [15:0]            carry_parcel_q;
   logic [`IFU_PC_W-1:0]   carry_pc_q;
   logic                   carry_err_q;

   parcels_t               parcels;
   logic [PIDX_W-1:0]      cur_idx;
   logic [15:0]            cur_parcel;
   logic [15:0]            nxt_parcel;
   instr_len_e             cur_len;
   logic [`IFU_PC_W-1:0]   cur_pc;
   logic [PIDX_W-1:0]      nxt_idx;           // parcel after this instruction
   logic                   straddle;
   logic                   last_used;
   logic                   take;

   //**********************************************************************
   // parcel select and length decode
   //**********************************************************************
   assign parcels    = head_i.data;
   assign cur_idx    = mid_q ? idx_q : head_i.start;          // fresh block starts at start
   assign cur_parcel = parcels[cur_idx];
   assign nxt_parcel = parcels[cur_idx + PIDX_W'(1)];
   assign cur_len    = decode_len(cur_parcel);
   assign cur_pc     = {head_i.pc[`IFU_PC_W-1:PIDX_W+1], cur_idx, 1'b0};

   // 32-bit opcode in the last parcel, upper half in the next block
   assign straddle = head_valid_i && !carry_vld_q && (cur_len == LEN_32) && (cur_idx == LAST);

   //**********************************************************************
   // instruction build
   //**********************************************************************
   always_comb begin
      if (carry_vld_q) begin
         instr_o.pc    = carry_pc_q;                  // pc of the first half
         instr_o.instr = {parcels[0], carry_parcel_q};
         instr_o.pc4   = 1'b1;
         instr_o.fault = carry_err_q | head_i.err;    // fault from either block
         nxt_idx       = PIDX_W'(1);
      end else if (cur_len == LEN_32) begin
         instr_o.pc    = cur_pc;
         instr_o.instr = {nxt_parcel, cur_parcel};
         instr_o.pc4   = 1'b1;
         instr_o.fault = head_i.err;
         nxt_idx       = cur_idx + PIDX_W'(2);
      end else begin
         instr_o.pc    = cur_pc;
         instr_o.instr = {16'h0000, cur_parcel};     // compressed
         instr_o.pc4   = 1'b0;
         instr_o.fault = head_i.err;
         nxt_idx       = cur_idx + PIDX_W'(1);
      end
   end

   // index wraps to zero exactly when the instruction ends on the last parcel
   assign last_used = (nxt_idx == '0);

   assign instr_valid_o = head_valid_i && !straddle && !flush_i;
   assign take          = instr_valid_o && dec_ready_i;
   assign pop_o         = (take && last_used) || (straddle && !flush_i);

   //**********************************************************************
   // parcel index and carry state
   //**********************************************************************
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         idx_q       <= '0;
         mid_q       <= 1'b0;
         carry_vld_q <= 1'b0;
      end else if (flush_i) begin
         mid_q       <= 1'b0;                       // next head starts fresh
         carry_vld_q <= 1'b0;
      end else if (straddle) begin
         mid_q       <= 1'b0;                       // block popped, wait for the next
         carry_vld_q <= 1'b1;
      end else if (take) begin
         carry_vld_q <= 1'b0;
         mid_q       <= !last_used;
         idx_q       <= nxt_idx;
      end
   end

   // lower half of a straddling instruction
   always_ff @(posedge clk) begin
      if (straddle) begin
         carry_parcel_q <= cur_parcel;
         carry_pc_q     <= cur_pc;
         carry_err_q    <= head_i.err;
      end
   end

endmodule

// ==== hdl/ifu_top.sv ====
//**********************************************************************
// instruction fetch unit top: fetch controller, fetch buffer, aligner
//**********************************************************************
`timescale 1ns/1ps
`include "ifu_defines.svh"

module ifu_top (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     flush_i,
   input  logic [`IFU_PC_W-1:0]     flush_pc_i,
   input  logic                     flush_noredir_i,
   output logic                     mem_req_o,          // memory port
   output logic [`IFU_PC_W-1:0]     mem_addr_o,
   input  logic                     mem_rsp_valid_i,
   input  logic [`IFU_BLK_W-1:0]    mem_rsp_data_i,
   input  logic                     mem_rsp_err_i,
   input  logic                     dec_ready_i,        // decode side
   output ifu_pkg::instr_pkt_t      instr_o,
   output logic                     instr_valid_o
);
   import ifu_pkg::*;

   fetch_blk_t   fetch_blk;        // response block into the buffer
   logic         blk_push;
   fetch_blk_t   head_blk;         // buffer head to aligner
   logic         head_valid;
   logic         pop;
   logic         credit;           // freed entry back to fetch

   ifu_fetch_ctl ifc (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .flush_i         (flush_i),
      .flush_pc_i      (flush_pc_i),
      .flush_noredir_i (flush_noredir_i),
      .credit_i        (credit),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_data_i  (mem_rsp_data_i),
      .mem_rsp_err_i   (mem_rsp_err_i),
      .mem_req_o       (mem_req_o),
      .mem_addr_o      (mem_addr_o),
      .blk_push_o      (blk_push),
      .blk_o           (fetch_blk)
   );

   ifu_fetch_buf fb (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .flush_i      (flush_i),
      .blk_push_i   (blk_push),
      .blk_i        (fetch_blk),
      .pop_i        (pop),
      .head_o       (head_blk),
      .head_valid_o (head_valid),
      .credit_o     (credit)
   );

   ifu_aligner aln (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .flush_i       (flush_i),
      .head_i        (head_blk),
      .head_valid_i  (head_valid),
      .dec_ready_i   (dec_ready_i),
      .pop_o         (pop),
      .instr_o       (instr_o),
      .instr_valid_o (instr_valid_o)
   );

endmodule

// ==== tests/tb_clkgen.sv ====
//**********************************************************************
// testbench clock source
//**********************************************************************
`timescale 1ns/1ps

module tb_clkgen #(
   parameter real PERIOD = 100.0                // ns
) (
   output logic clk_o
);

   initial clk_o = 1'b0;                        // first falling edge one period in

   always #(PERIOD / 2.0) clk_o = ~clk_o;

endmodule

// ==== tests/tb_ifu.sv ====
//**********************************************************************
// fetch unit testbench: memory model, stimulus file reader, stream
// checks for redirect, halt, straddle, fault and back-pressure
//**********************************************************************
`timescale 1ns/1ps
`include "ifu_defines.svh"

module tb_ifu;
   import ifu_pkg::*;

   localparam int MAX_WAIT   = 200;             // cycles allowed per instruction
   localparam int HALT_WAIT  = 10;              // cycles for fetch to go quiet
   localparam int HALT_WATCH = 16;              // quiet cycles observed after halt

   logic                   clk;
   logic                   rst_n_i;
   logic                   flush_i;
   logic [`IFU_PC_W-1:0]   flush_pc_i;
   logic                   flush_noredir_i;
   logic                   mem_req_o;
   logic [`IFU_PC_W-1:0]   mem_addr_o;
   logic                   mem_rsp_valid_i;
   logic [`IFU_BLK_W-1:0]  mem_rsp_data_i;
   logic                   mem_rsp_err_i;
   logic                   dec_ready_i;
   instr_pkt_t             instr_o;
   logic                   instr_valid_o;

   logic [`IFU_BLK_W:0]    mem_img [logic [31:0]];   // {err, data} per block address
   int                     fd;
   logic                   rsp_pend;                 // request seen last cycle
   logic [31:0]            rsp_addr;
   logic                   taken;                    // transfer at the coming edge
   instr_pkt_t             taken_pkt;
   logic                   req_seen;                 // mem_req_o in this cycle
   int                     req_cnt;                  // requests since reset or flush
   int                     done_blks;                // blocks fully consumed
   logic [31:0]            first_blk;                // expected block of the first request

   tb_clkgen #(.PERIOD(100.0)) clkgen (.clk_o(clk));

   ifu_top UUT (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .flush_i         (flush_i),
      .flush_pc_i      (flush_pc_i),
      .flush_noredir_i (flush_noredir_i),
      .mem_req_o       (mem_req_o),
      .mem_addr_o      (mem_addr_o),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_data_i  (mem_rsp_data_i),
      .mem_rsp_err_i   (mem_rsp_err_i),
      .dec_ready_i     (dec_ready_i),
      .instr_o         (instr_o),
      .instr_valid_o   (instr_valid_o)
   );

   //**********************************************************************
   // error exit and value check
   //**********************************************************************
   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("FAILED %s expected %08h actual %08h", name, exp, act);
         stop_run("value mismatch");
      end
   endtask

   // unlisted blocks get a pattern built from the full address
   function automatic logic [`IFU_BLK_W:0] mem_word(input logic [31:0] addr);
      if (mem_img.exists(addr))
         return mem_img[addr];
      return {1'b0, ~addr, addr ^ 32'h9e37_79b9};
   endfunction

   //**********************************************************************
   // one falling edge: sample, memory answer, outstanding bound
   //**********************************************************************
   task automatic next_cycle(input logic ready);
      logic [`IFU_BLK_W:0] word;
      logic [31:0]         end_addr;
      @(negedge clk);
      taken       = instr_valid_o && ready;      // ready holds through the coming edge
      taken_pkt   = instr_o;
      req_seen    = mem_req_o;
      dec_ready_i = ready;
      mem_rsp_valid_i = rsp_pend;                // answer exactly one cycle late
      if (rsp_pend) begin
         word           = mem_word(rsp_addr);
         mem_rsp_data_i = word[`IFU_BLK_W-1:0];
         mem_rsp_err_i  = word[`IFU_BLK_W];
      end else begin
         mem_rsp_data_i = '0;
         mem_rsp_err_i  = 1'b0;
      end
      rsp_pend = mem_req_o;
      rsp_addr = mem_addr_o;
      if (mem_req_o) begin
         // requests walk block by block from the first one
         check_value("fetch address", first_blk + 32'(req_cnt) * 32'd8, mem_addr_o);
         req_cnt++;
      end
      if (taken) begin
         end_addr  = taken_pkt.pc + (taken_pkt.pc4 ? 32'd4 : 32'd2);
         done_blks = int'((end_addr - first_blk) >> 3);
      end
      // one extra block while the aligner holds the low half of a straddler
      if (req_cnt - done_blks > `IFU_FB_DEPTH + 1)
         stop_run("too many fetch blocks requested ahead of decode");
   endtask

   //**********************************************************************
   // stimulus file access
   //**********************************************************************
   task automatic read_tag(output logic [63:0] tag);
      int               code;
      logic [8*256-1:0] rest;
      tag  = '0;
      code = $fscanf(fd, "%s", tag);
      while (code == 1 && tag == "#") begin      // skip comment lines
         code = $fgets(rest, fd);
         code = $fscanf(fd, "%s", tag);
      end
      if (code != 1)
         tag = '0;                               // end of file
   endtask

   //**********************************************************************
   // flush, halt and instruction stream steps
   //**********************************************************************
   task automatic apply_flush(input logic [31:0] pc, input logic noredir);
      next_cycle(1'b0);                          // old request counted before the reset
      req_cnt         = 0;
      done_blks       = 0;
      first_blk       = {pc[31:3], 3'b000};      // block holding the target
      flush_i         = 1'b1;
      flush_pc_i      = pc;
      flush_noredir_i = noredir;
      next_cycle(1'b0);
      flush_i         = 1'b0;
      flush_noredir_i = 1'b0;
      if (!noredir)
         check_value("redirect request after flush", 32'd1, 32'(req_seen));
   endtask

   task automatic expect_halt(input string name);
      int waited;
      waited = 0;
      next_cycle(1'b1);                          // any output would transfer
      while (req_seen || taken) begin
         waited++;
         if (waited > HALT_WAIT)
            stop_run("fetch requests or output did not stop after the halt flush");
         next_cycle(1'b1);
      end
      for (int k = 0; k < HALT_WATCH; k++) begin
         next_cycle(1'b1);
         check_value({name, " halt mem_req_o"}, 32'd0, 32'(req_seen));
         check_value({name, " halt instr transfer"}, 32'd0, 32'(taken));
      end
   endtask

   task automatic expect_stream(input string name, input int count);
      logic [63:0] tag;
      logic [31:0] e_pc;
      logic [31:0] e_instr;
      logic [31:0] e_pc4;
      logic [31:0] e_fault;
      int          code;
      int          waited;
      logic        got;
      string       tn;
      for (int i = 0; i < count; i++) begin
         read_tag(tag);
         if (tag != "E")
            stop_run("stimulus file is missing an expected instruction line");
         code   = $fscanf(fd, "%h %h %h %h", e_pc, e_instr, e_pc4, e_fault);
         if (code != 4)
            stop_run("stimulus file has a malformed expected instruction line");
         got    = 1'b0;
         waited = 0;
         while (!got) begin
            next_cycle(($urandom % 4) != 0);     // random stalls
            got = taken;
            if (!got) begin
               waited++;
               if (waited > MAX_WAIT)
                  stop_run($sformatf("%s: instruction %0d never reached decode", name, i));
            end
         end
         tn = $sformatf("%s instr %0d", name, i);
         check_value({tn, " pc"}, e_pc, taken_pkt.pc);
         check_value({tn, " instr"}, e_instr, taken_pkt.instr);
         check_value({tn, " pc4"}, e_pc4, 32'(taken_pkt.pc4));
         check_value({tn, " fault"}, e_fault, 32'(taken_pkt.fault));
      end
   endtask

   //**********************************************************************
   // main sequence
   //**********************************************************************
   initial begin
      logic [63:0] tag;
      logic [31:0] addr;
      logic [63:0] data;
      logic [31:0] flag;
      int          cnt;
      int          code;
      int          step_no;
      rst_n_i         = 1'b0;
      flush_i         = 1'b0;
      flush_pc_i      = '0;
      flush_noredir_i = 1'b0;
      mem_rsp_valid_i = 1'b0;
      mem_rsp_data_i  = '0;
      mem_rsp_err_i   = 1'b0;
      dec_ready_i     = 1'b0;
      rsp_pend        = 1'b0;
      rsp_addr        = '0;
      req_cnt         = 0;
      done_blks       = 0;
      first_blk       = `IFU_RESET_PC & 32'hffff_fff8;
      step_no         = 0;
      void'($urandom(32'hcfbd16e4));             // seeds the generator once
      fd = $fopen("tests/ifu_stimulus.txt", "r");
      if (fd == 0)
         stop_run("cannot open the stimulus file tests/ifu_stimulus.txt");
      for (int k = 0; k < 8; k++) begin
         @(negedge clk);
         check_value("reset mem_req_o", 32'd0, 32'(mem_req_o));
         check_value("reset instr_valid_o", 32'd0, 32'(instr_valid_o));
      end
      rst_n_i = 1'b1;
      next_cycle(1'b0);
      check_value("first request after reset", 32'd1, 32'(req_seen));
      read_tag(tag);
      while (tag != '0) begin
         if (tag == "M") begin
            code = $fscanf(fd, "%h %h %h", addr, data, flag);
            if (code != 3)
               stop_run("stimulus file has a malformed memory line");
            mem_img[addr] = {flag[0], data};
         end else if (tag == "R") begin
            code = $fscanf(fd, "%d", cnt);
            if (code != 1)
               stop_run("stimulus file has a malformed reset step line");
            expect_stream($sformatf("step %0d reset", step_no), cnt);
            step_no++;
         end else if (tag == "S") begin
            code = $fscanf(fd, "%h %h %d", addr, flag, cnt);
            if (code != 3)
               stop_run("stimulus file has a malformed flush step line");
            apply_flush(addr, flag[0]);
            if (flag[0])
               expect_halt($sformatf("step %0d", step_no));
            else
               expect_stream($sformatf("step %0d redirect", step_no), cnt);
            step_no++;
         end else begin
            stop_run("unknown line type in the stimulus file");
         end
         read_tag(tag);
      end
      $fclose(fd);
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/ifu_pkg.sv
hdl/ifu_fetch_ctl.sv
hdl/ifu_fetch_buf.sv
hdl/ifu_aligner.sv
hdl/ifu_top.sv
tests/tb_clkgen.sv
tests/tb_ifu.sv

// ==== Makefile ====
# Verilator build and run of the instruction fetch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_ifu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wall

FILELIST  := sources.f
SRCS      := $(shell grep -v '^+' $(FILELIST)) hdl/ifu_defines.svh
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)

check: run
	@grep -q "Test completed successfully" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/ifu_stimulus.txt ====
# M block_addr data(parcel 0 in low halfword) err | R count | S flush_pc noredir count
# E pc instr pc4 fault, one line per expected decode transfer
M 00000100 458500a000934501 0
M 00000108 0193050500100113 0
M 00000110 0031023346090200 0
M 00000118 0000001347014681 0
M 00000200 0293451545114501 0
M 00000208 0060031345190050 1
M 00000210 000000134521451d 0
# mixed stream from reset with a straddler at 10e
R 11
E 00000100 00004501 0 0
E 00000102 00a00093 1 0
E 00000106 00004585 0 0
E 00000108 00100113 1 0
E 0000010c 00000505 0 0
E 0000010e 02000193 1 0
E 00000112 00004609 0 0
E 00000114 00310233 1 0
E 00000118 00004681 0 0
E 0000011a 00004701 0 0
E 0000011c 00000013 1 0
# redirect onto the last parcel of a block
S 0000010e 0 4
E 0000010e 02000193 1 0
E 00000112 00004609 0 0
E 00000114 00310233 1 0
E 00000118 00004681 0 0
# halt without redirect
S 00000000 1 0
# resume into the faulting block at 208
S 00000202 0 7
E 00000202 00004511 0 0
E 00000204 00004515 0 0
E 00000206 00500293 1 1
E 0000020a 00004519 0 1
E 0000020c 00600313 1 1
E 00000210 0000451d 0 0
E 00000212 00004521 0 0
